// File: hdl/wrf_pkg.sv
// Register file base types
// Machine word type and width
// Register index map of the register block
`default_nettype none

package wrf_pkg;

  // Word width of the minicomputer
  parameter int WORD_W = 16;

  // One machine word
  typedef logic [WORD_W-1:0] word_t;

  // Register index map, P sits at index 2
  typedef enum logic [2:0] {
    reg_sts = 3'd0, // Status, plain register here
    reg_d   = 3'd1,
    reg_p   = 3'd2, // Program counter, not in the general file
    reg_b   = 3'd3,
    reg_l   = 3'd4, // Link
    reg_a   = 3'd5,
    reg_t   = 3'd6,
    reg_x   = 3'd7
  } reg_idx_e;

  // Number of general registers, all indexes except P
  parameter int NUM_GREGS = 7;

  // Width of a general register slot number
  parameter int SLOT_W = 3;

endpackage : wrf_pkg

`default_nettype wire

// File: hdl/wrf_ctl_pkg.sv
// Register block command types
// Opcode enum, command word, P source select, decoded controls
`default_nettype none

package wrf_ctl_pkg;

  typedef enum logic [2:0] {
    op_nop   = 3'd0, // Hold P
    op_fetch = 3'd1, // P plus one
    op_skip  = 3'd2, // P plus two
    op_jump  = 3'd3, // P plus signed disp
    op_write = 3'd4, // External data to dst
    op_copy  = 3'd5  // src to dst
  } wrf_op_e;

  // Command as seen at the block inputs, 38 bits
  typedef struct packed {
    wrf_op_e           op;
    wrf_pkg::reg_idx_e dst;
    wrf_pkg::reg_idx_e src;
    logic signed [7:0] disp;  // Relative jump distance
    wrf_pkg::word_t    data;  // Write data
    logic [4:0]        spare; // Tied low
  } wrf_cmd_t;

  // Source of the next P value
  typedef enum logic [1:0] {
    p_hold = 2'd0, // Recirculate
    p_next = 2'd1, // Next-address adder
    p_rb   = 2'd2  // RB write bus
  } p_src_e;

  // Decoded control levels, 26 bits
  typedef struct packed {
    p_src_e            p_src;
    wrf_pkg::word_t    add_offset;  // Adder operand, sign-extended
    logic              wr_en;       // General register write
    wrf_pkg::reg_idx_e wr_idx;
    logic              rb_from_reg; // RB driven by register read port
    wrf_pkg::reg_idx_e rd_idx;
  } wrf_ctl_t;

endpackage : wrf_ctl_pkg

`default_nettype wire

// File: hdl/wrf_cmd_decode.sv
// Command decoder of the register block
// Maps one command to P source, adder operand and write controls
// Redirects register writes aimed at P onto the P source select
`timescale 1ns/1ps
`default_nettype none

module wrf_cmd_decode (
  input  wire wrf_ctl_pkg::wrf_cmd_t cmd,
  output      wrf_ctl_pkg::wrf_ctl_t ctl
);

  import wrf_pkg::*;
  import wrf_ctl_pkg::*;

  // Fixed increments for fetch and skip
  localparam word_t INC_FETCH = word_t'(1);
  localparam word_t INC_SKIP  = word_t'(2);

  always_comb begin
    // Defaults give a hold with no write
    ctl.p_src       = p_hold;
    ctl.add_offset  = '0;
    ctl.wr_en       = 1'b0;
    ctl.wr_idx      = cmd.dst;
    ctl.rb_from_reg = 1'b0;
    ctl.rd_idx      = cmd.src; // Read port always follows src

    case (cmd.op)
      op_fetch: begin
        ctl.p_src      = p_next;
        ctl.add_offset = INC_FETCH;
      end
      op_skip: begin
        ctl.p_src      = p_next;
        ctl.add_offset = INC_SKIP;
      end
      op_jump: begin
        ctl.p_src      = p_next;
        // Sign-extend the 8-bit displacement
        ctl.add_offset = {{(WORD_W-8){cmd.disp[7]}}, cmd.disp};
      end
      op_write, op_copy: begin
        ctl.rb_from_reg = (cmd.op == op_copy); // Copy puts src on RB
        if (cmd.dst == reg_p) begin
          ctl.p_src = p_rb;    // P loads from RB
        end else begin
          ctl.wr_en = 1'b1;    // General register takes RB
        end
      end
      default: begin
        ctl.p_src = p_hold;    // op_nop and unused codes
      end
    endcase
  end

endmodule : wrf_cmd_decode

`default_nettype wire

// File: hdl/wrf_next_addr.sv
// Next-address adder of the P register
// Forms P plus increment, skip or relative displacement
`timescale 1ns/1ps
`default_nettype none

module wrf_next_addr (
  input  wire wrf_pkg::word_t p,
  input  wire wrf_pkg::word_t offset,
  output      wrf_pkg::word_t nlca
);

  import wrf_pkg::*;

  word_t gen;   // Carry generate per bit
  word_t prop;  // Carry propagate per bit
  word_t carry; // Carry into each bit

  // Generate and propagate terms
  assign gen  = p & offset;
  assign prop = p ^ offset;

  // Carry chain, no carry in
  always_comb begin
    carry[0] = 1'b0;
    for (int i = 1; i < WORD_W; i++) begin
      carry[i] = gen[i-1] | (prop[i-1] & carry[i-1]);
    end
  end

  // Carry out of the top bit is dropped so the sum wraps
  assign nlca = prop ^ carry;

endmodule : wrf_next_addr

`default_nettype wire

// File: hdl/wrf_preg.sv
// Program counter P and its shadow PR
// Three-way source mux: hold, next address, RB bus
// P loads on the alu_clk strobe, PR on the alu_clk_n strobe
`timescale 1ns/1ps
`default_nettype none

module wrf_preg #(
  parameter wrf_pkg::word_t RESET_P = '0 // P and PR after reset
) (
  input  wire                      sysclk,
  input  wire                      rst_n,
  input  wire                      alu_clk,   // ALU phase strobe, P load
  input  wire                      alu_clk_n, // Opposite phase strobe, PR load
  input  wire wrf_ctl_pkg::p_src_e p_src,
  input  wire wrf_pkg::word_t      nlca,      // From next-address adder
  input  wire wrf_pkg::word_t      rb,        // RB write bus
  output      wrf_pkg::word_t      p,
  output      wrf_pkg::word_t      pr
);

  import wrf_pkg::*;
  import wrf_ctl_pkg::*;

  word_t p_in; // Selected next value, shared by P and PR

  // Source mux
  always_comb begin
    case (p_src)
      p_hold:  p_in = p;
      p_next:  p_in = nlca;
      p_rb:    p_in = rb;
      default: p_in = p; // Unused code holds
    endcase
  end

  // P register, ALU phase
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      p <= RESET_P;
    end else if (alu_clk) begin
      p <= p_in;
    end
  end

  // PR shadow, opposite phase
  // Takes the mux output, so a pending fetch shows up here first
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      pr <= RESET_P;
    end else if (alu_clk_n) begin
      pr <= p_in;
    end
  end

endmodule : wrf_preg

`default_nettype wire

// File: hdl/wrf_regs.sv
// General registers STS, D, B, L, A, T and X
// One write port, strobed by alu_clk
// Source read port and external read port, both return P at index 2
`timescale 1ns/1ps
`default_nettype none

module wrf_regs (
  input  wire                    sysclk,
  input  wire                    rst_n,
  input  wire                    wr_en,
  input  wire                    alu_clk,
  input  wire wrf_pkg::reg_idx_e wr_idx,
  input  wire wrf_pkg::reg_idx_e rd_idx, // Source port select
  input  wire wrf_pkg::reg_idx_e rd_sel, // External port select
  input  wire wrf_pkg::word_t    wr_data,
  input  wire wrf_pkg::word_t    p,      // Current P for index 2
  output      wrf_pkg::word_t    src_data,
  output      wrf_pkg::word_t    rd_data
);

  import wrf_pkg::*;

  word_t gregs [NUM_GREGS]; // Seven words, P has no slot

  // Squeeze the index map around P into slots 0..6
  function automatic logic [SLOT_W-1:0] slot_of(input reg_idx_e idx);
    logic [SLOT_W-1:0] raw;
    raw = SLOT_W'(idx);
    if (raw > SLOT_W'(reg_p)) begin
      return raw - SLOT_W'(1); // Above P shifts down
    end
    return raw;
  endfunction

  // Read port with P bypass
  function automatic word_t read_reg(input reg_idx_e idx, input word_t p_val,
                                     input word_t regs [NUM_GREGS]);
    if (idx == reg_p) begin
      return p_val;
    end
    return regs[slot_of(idx)];
  endfunction

  // Write port
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_GREGS; i++) begin
        gregs[i] <= '0;
      end
    end else if (wr_en && alu_clk) begin
      gregs[slot_of(wr_idx)] <= wr_data; // P itself is loaded in wrf_preg
    end
  end

  assign src_data = read_reg(rd_idx, p, gregs); // Feeds the RB bus on copy
  assign rd_data  = read_reg(rd_sel, p, gregs); // Block output

endmodule : wrf_regs

`default_nettype wire

// File: hdl/wrf_rblock.sv
// Register block top level
// Command decoder, next-address adder, P register, general registers
// RB bus select between external data and register read port
`timescale 1ns/1ps
`default_nettype none

module wrf_rblock #(
  parameter wrf_pkg::word_t RESET_P = '0 // Start address after reset
) (
  input  wire                        sysclk,
  input  wire                        rst_n,
  input  wire                        alu_clk,
  input  wire                        alu_clk_n,
  input  wire wrf_ctl_pkg::wrf_cmd_t cmd,
  input  wire wrf_pkg::reg_idx_e     rd_sel,
  output      wrf_pkg::word_t        p,
  output      wrf_pkg::word_t        pr,
  output      wrf_pkg::word_t        rd_data
);

  import wrf_pkg::*;
  import wrf_ctl_pkg::*;

  wrf_ctl_t ctl;      // Decoded control levels
  word_t    nlca;     // Next address
  word_t    src_data; // Register named by ctl.rd_idx
  word_t    rb;       // RB write bus

  // Copy takes a register, write takes the command data
  assign rb = ctl.rb_from_reg ? src_data : cmd.data;

  wrf_cmd_decode u_decode (
    .cmd (cmd),
    .ctl (ctl)
  );

  wrf_next_addr u_next_addr (
    .p      (p),
    .offset (ctl.add_offset),
    .nlca   (nlca)
  );

  wrf_preg #(
    .RESET_P (RESET_P)
  ) u_preg (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .alu_clk   (alu_clk),
    .alu_clk_n (alu_clk_n),
    .p_src     (ctl.p_src),
    .nlca      (nlca),
    .rb        (rb),
    .p         (p),
    .pr        (pr)
  );

  wrf_regs u_regs (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .wr_en    (ctl.wr_en),
    .alu_clk  (alu_clk),
    .wr_idx   (ctl.wr_idx),
    .rd_idx   (ctl.rd_idx),
    .rd_sel   (rd_sel),
    .wr_data  (rb),       // Same bus that feeds P
    .p        (p),
    .src_data (src_data),
    .rd_data  (rd_data)
  );

endmodule : wrf_rblock

`default_nettype wire

// File: tb/tb_wrf_tasks.svh
// Directed tests of the register block
// Reset values, fetch and skip with wrap, jumps, register moves, PR capture
`ifndef TB_WRF_TASKS_SVH
`define TB_WRF_TASKS_SVH

  task automatic check_after_reset();
    check_state(); // P and PR at 0100, registers zero
  endtask

  task automatic step_and_wrap();
    repeat (3) drive_cmd(make_cmd(op_fetch, reg_sts, reg_sts, 8'h00, 16'h0), 1'b1, 1'b0);
    repeat (3) drive_cmd(make_cmd(op_skip, reg_sts, reg_sts, 8'h00, 16'h0), 1'b1, 1'b0);
    // No strobe, so P must not move
    drive_cmd(make_cmd(op_fetch, reg_sts, reg_sts, 8'h00, 16'h0), 1'b0, 1'b0);
    drive_cmd(make_cmd(op_skip, reg_sts, reg_sts, 8'h00, 16'h0), 1'b0, 1'b0);
    drive_cmd(make_cmd(op_jump, reg_sts, reg_sts, 8'(rand_bits(8)), 16'h0), 1'b0, 1'b0);
    // Wrap at the top of the address space
    drive_cmd(make_cmd(op_write, reg_p, reg_sts, 8'h00, 16'hffff), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_fetch, reg_sts, reg_sts, 8'h00, 16'h0), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_write, reg_p, reg_sts, 8'h00, 16'hfffe), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_skip, reg_sts, reg_sts, 8'h00, 16'h0), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_write, reg_p, reg_sts, 8'h00, 16'hffff), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_skip, reg_sts, reg_sts, 8'h00, 16'h0), 1'b1, 1'b0);
  endtask

  task automatic relative_jumps();
    logic [7:0] disp;
    for (int i = 0; i < 16; i++) begin
      disp = {i[0], 7'(rand_bits(7))}; // Odd passes go backward
      drive_cmd(make_cmd(op_jump, reg_sts, reg_sts, disp, 16'h0), 1'b1, 1'b0);
    end
  endtask

  task automatic register_moves();
    for (int i = 0; i < 8; i++) begin
      if (i != 2) begin
        drive_cmd(make_cmd(op_write, reg_idx_e'(i[2:0]), reg_sts, 8'h00,
                           word_t'(rand_bits(16))), 1'b1, 1'b0);
      end
    end
    drive_cmd(make_cmd(op_write, reg_p, reg_sts, 8'h00, word_t'(rand_bits(16))), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_copy, reg_d, reg_a, 8'h00, 16'h0), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_copy, reg_p, reg_x, 8'h00, 16'h0), 1'b1, 1'b0);  // Jump via X
    drive_cmd(make_cmd(op_copy, reg_t, reg_p, 8'h00, 16'h0), 1'b1, 1'b0);  // Save P in T
  endtask

  task automatic shadow_capture();
    drive_cmd(make_cmd(op_fetch, reg_sts, reg_sts, 8'h00, 16'h0), 1'b1, 1'b0);
    drive_cmd(make_cmd(op_nop, reg_sts, reg_sts, 8'h00, 16'h0), 1'b0, 1'b1); // PR = P
    drive_cmd(make_cmd(op_fetch, reg_sts, reg_sts, 8'h00, 16'h0), 1'b0, 1'b1); // PR = P + 1
  endtask

`endif

// File: tb/tb_wrf_rblock.sv
// Testbench top of the register block
// Clock, reset, LFSR, watchdog, reference model and closing report
// Directed tests come from tb_wrf_tasks.svh
`timescale 1ns/1ps
`default_nettype none

module tb_wrf_rblock;

  import wrf_pkg::*;
  import wrf_ctl_pkg::*;

  localparam int CLK_PERIOD     = 8;  // ns
  localparam int RESET_CYCLES   = 5;
  localparam int CMD_COUNT      = 60; // Upper bound on strobed and idle commands
  localparam int CYCLES_PER_CMD = 3;  // Wait edge, strobe edge, read-back slack
  localparam int MARGIN_NS      = 200;
  localparam int WATCHDOG_NS    =
    (RESET_CYCLES + CMD_COUNT * CYCLES_PER_CMD) * CLK_PERIOD + MARGIN_NS;

  logic     sysclk;
  logic     rst_n;
  logic     alu_clk;
  logic     alu_clk_n;
  wrf_cmd_t cmd;
  reg_idx_e rd_sel;
  word_t    p;
  word_t    pr;
  word_t    rd_data;

  word_t       ref_p;        // Model of P
  word_t       ref_pr;       // Model of PR
  word_t       ref_regs [8]; // Index 2 unused, P lives in ref_p
  logic [31:0] lfsr_state = 32'h1ebb_ed2e;
  int          errors = 0;
  int          checks = 0;

  wrf_rblock #(
    .RESET_P (16'h0100)
  ) dut (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .alu_clk   (alu_clk),
    .alu_clk_n (alu_clk_n),
    .cmd       (cmd),
    .rd_sel    (rd_sel),
    .p         (p),
    .pr        (pr),
    .rd_data   (rd_data)
  );

  initial begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic wrf_cmd_t make_cmd(input wrf_op_e op, input reg_idx_e dst,
                                        input reg_idx_e src, input logic [7:0] disp,
                                        input word_t data);
    wrf_cmd_t c;
    c.op    = op;
    c.dst   = dst;
    c.src   = src;
    c.disp  = disp;
    c.data  = data;
    c.spare = '0; // Unused bits low
    return c;
  endfunction

  function automatic word_t ref_value(input reg_idx_e idx);
    return (idx == reg_p) ? ref_p : ref_regs[idx];
  endfunction

  // Value the P source would present for this command
  function automatic word_t select_value(input wrf_cmd_t c);
    int disp_val;
    // Two's complement byte as a signed word count
    disp_val = c.disp[7] ? int'(c.disp[6:0]) - 128 : int'(c.disp[6:0]);
    case (c.op)
      op_fetch: return ref_p + 16'd1;
      op_skip:  return ref_p + 16'd2;
      op_jump:  return ref_p + word_t'(disp_val);
      op_write: return (c.dst == reg_p) ? c.data : ref_p;
      op_copy:  return (c.dst == reg_p) ? ref_value(c.src) : ref_p;
      default:  return ref_p;
    endcase
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0.1f ns: %s is %h, expected %h", $realtime, name, got, exp);
    end
  endtask

  // P, PR and every read index
  task automatic check_state();
    check_word("p", p, ref_p);
    check_word("pr", pr, ref_pr);
    for (int i = 0; i < 8; i++) begin
      rd_sel = reg_idx_e'(i[2:0]);
      #0.5;
      check_word($sformatf("rd_data[%s]", rd_sel.name()), rd_data, ref_value(rd_sel));
    end
  endtask

  // One command for one cycle with the chosen strobes, then model update and check
  task automatic drive_cmd(input wrf_cmd_t c, input logic strobe, input logic strobe_n);
    word_t sel;
    word_t wr_val;
    @(posedge sysclk);
    #1;
    cmd       = c;
    alu_clk   = strobe;
    alu_clk_n = strobe_n;
    sel       = select_value(c);
    wr_val    = (c.op == op_copy) ? ref_value(c.src) : c.data;
    @(posedge sysclk);
    #1;
    alu_clk   = 1'b0;
    alu_clk_n = 1'b0;
    cmd       = make_cmd(op_nop, reg_sts, reg_sts, 8'h00, 16'h0000);
    if (strobe) begin
      ref_p = sel;
      if ((c.op == op_write || c.op == op_copy) && c.dst != reg_p) begin
        ref_regs[c.dst] = wr_val;
      end
    end
    if (strobe_n) begin
      ref_pr = sel; // Shadow sees the same mux value
    end
    check_state();
  endtask

`include "tb_wrf_tasks.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    alu_clk   = 1'b0;
    alu_clk_n = 1'b0;
    rd_sel    = reg_sts;
    cmd       = make_cmd(op_nop, reg_sts, reg_sts, 8'h00, 16'h0000);
    ref_p     = 16'h0100; // RESET_P of this instance
    ref_pr    = 16'h0100;
    for (int i = 0; i < 8; i++) ref_regs[i] = '0;
    repeat (RESET_CYCLES) @(posedge sysclk);
    #1;
    rst_n = 1'b1;
    check_after_reset();
    step_and_wrap();
    relative_jumps();
    register_moves();
    shadow_capture();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_wrf_rblock

`default_nettype wire

// File: filelist.f
+incdir+tb
hdl/wrf_pkg.sv
hdl/wrf_ctl_pkg.sv
hdl/wrf_cmd_decode.sv
hdl/wrf_next_addr.sv
hdl/wrf_preg.sv
hdl/wrf_regs.sv
hdl/wrf_rblock.sv
tb/tb_wrf_rblock.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator.
# The run fails if the log holds the fail message.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_wrf_rblock

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module "${TOP}" \
  -Mdir "${OBJ_DIR}" \
  -o sim
status=$?
if [ ${status} -ne 0 ]; then
  echo "Verilator build failed with status ${status}"
  exit 1
fi

"./${OBJ_DIR}/sim" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
  echo "Simulation exited with status ${status}"
  exit 1
fi

if grep -qF -- "** FAIL **" "${LOG}"; then
  echo "Testbench reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
